// ==== Makefile ====
TOP  := bfp_norm_tb
SRCS := $(shell cat bfp_norm.f)

.PHONY: all run clean

all: run

obj_dir/V$(TOP): bfp_norm.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f bfp_norm.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// ==== bfp_norm.f ====
hdl/bfp_pkg.sv
hdl/add_lzc.sv
hdl/bfp_dispatch.sv
hdl/bfp_lane.sv
hdl/bfp_collect.sv
hdl/bfp_norm_top.sv
testbench/bfp_norm_chk.sv
testbench/bfp_norm_tb.sv

// ==== hdl/add_lzc.sv ====
`timescale 1ns/1ps

module add_lzc #(
    parameter int unsigned WIDTH = 2,
    // Set to 1 for leading zeros and to 0 for trailing zeros
    parameter bit          MODE  = 1'b0,
    // One level of the selector tree per count bit
    localparam int unsigned CNT_WIDTH = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
    input  logic [WIDTH-1:0]     in_i,
    output logic [CNT_WIDTH-1:0] cnt_o,
    output logic                 empty_o
);

    // The count is the index of the first set bit, seen from the LSB side
    // In leading zero mode the input is mirrored, so the MSB becomes index 0
    // A zero input raises empty_o and the count reads WIDTH - 1

    if (WIDTH == 1) begin : g_single
        // A lone bit has no zeros before it when set, and WIDTH - 1 is zero anyway
        assign cnt_o   = 1'b0;
        assign empty_o = ~in_i[0];
    end else begin : g_tree
        localparam int unsigned NUM_LEVELS = CNT_WIDTH;

        logic [WIDTH-1:0]                           in_tmp;
        logic [WIDTH-1:0][NUM_LEVELS-1:0]           index_lut;
        // Node n has children 2n+1 and 2n+2, the root is node 0
        logic [2**NUM_LEVELS-2:0]                   sel_nodes;
        logic [2**NUM_LEVELS-2:0][NUM_LEVELS-1:0]   index_nodes;

        // Mirror the vector for leading zero mode
        always_comb begin
            for (int unsigned i = 0; i < WIDTH; i++) begin
                in_tmp[i] = MODE ? in_i[WIDTH-1-i] : in_i[i];
            end
        end

        // Bit position of each input, as seen by the leaves
        for (genvar j = 0; j < WIDTH; j++) begin : g_index_lut
            assign index_lut[j] = NUM_LEVELS'(j);
        end

        for (genvar level = 0; level < NUM_LEVELS; level++) begin : g_levels
            localparam int unsigned BASE  = 2**level - 1;
            localparam int unsigned CHILD = 2**(level + 1) - 1;

            if (level == NUM_LEVELS - 1) begin : g_leaves
                for (genvar k = 0; k < 2**level; k++) begin : g_node
                    if (unsigned'(2 * k + 1) < WIDTH) begin : g_pair
                        // Both inputs exist, the lower index wins
                        assign sel_nodes[BASE+k]   = in_tmp[2*k] | in_tmp[2*k+1];
                        assign index_nodes[BASE+k] = in_tmp[2*k] ? index_lut[2*k]
                                                                 : index_lut[2*k+1];
                    end else if (unsigned'(2 * k + 1) == WIDTH) begin : g_last
                        // Odd width leaves one input without a partner
                        assign sel_nodes[BASE+k]   = in_tmp[2*k];
                        assign index_nodes[BASE+k] = index_lut[2*k];
                    end else begin : g_pad
                        // Past the end of the vector, never selected
                        assign sel_nodes[BASE+k]   = 1'b0;
                        assign index_nodes[BASE+k] = '0;
                    end
                end
            end else begin : g_inner
                for (genvar l = 0; l < 2**level; l++) begin : g_node
                    assign sel_nodes[BASE+l] = sel_nodes[CHILD+2*l] | sel_nodes[CHILD+2*l+1];
                    // Left child covers the lower indices, so it takes priority
                    assign index_nodes[BASE+l] = sel_nodes[CHILD+2*l]
                                               ? index_nodes[CHILD+2*l]
                                               : index_nodes[CHILD+2*l+1];
                end
            end
        end

        assign empty_o = ~sel_nodes[0];
        // The tree alone gives a width dependent value for zero input, so pin it here
        assign cnt_o   = sel_nodes[0] ? index_nodes[0] : CNT_WIDTH'(WIDTH - 1);
    end

endmodule

// ==== hdl/bfp_collect.sv ====
`timescale 1ns/1ps

module bfp_collect (
    input  logic                                        clk_i,
    input  logic                                        rst_n_i,
    input  logic                                        res_valid_i,
    input  bfp_pkg::lane_res_t [bfp_pkg::NUM_LANES-1:0] res_i,
    output logic                                        rsp_valid_o,
    output bfp_pkg::bfp_rsp_t                           rsp_o
);

    // Last stage of the pipeline
    // The block shift is the smallest leading zero count among the lanes
    // that hold a nonzero value, so the largest lane ends up with its top
    // bit set and no lane overflows the mantissa width

    bfp_pkg::cnt_t              min_cnt;
    logic                       all_zero;
    bfp_pkg::cnt_t              shift;
    bfp_pkg::bfp_rsp_t          rsp_d;

    // Minimum count over non-empty lanes
    always_comb begin
        // MAG_WIDTH - 1 is the largest count a nonzero magnitude can have
        min_cnt  = bfp_pkg::cnt_t'(bfp_pkg::MAG_WIDTH - 1);
        all_zero = 1'b1;

        for (int unsigned i = 0; i < bfp_pkg::NUM_LANES; i++) begin
            if (!res_i[i].empty) begin
                all_zero = 1'b0;
                if (res_i[i].cnt < min_cnt) begin
                    min_cnt = res_i[i].cnt;
                end
            end
        end
    end

    // With nothing to normalize the shift is forced to zero
    assign shift = all_zero ? '0 : min_cnt;

    // Normalize every lane by the common shift
    always_comb begin
        for (int unsigned i = 0; i < bfp_pkg::NUM_LANES; i++) begin
            rsp_d.sign[i] = res_i[i].sign;
            // Empty lanes carry a zero magnitude and stay zero after the shift
            rsp_d.mant[i] = res_i[i].mag << shift;
        end
        rsp_d.shift    = shift;
        rsp_d.all_zero = all_zero;
    end

    // Response strobe, three cycles after the request in total
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= res_valid_i;
        end
    end

    // Response data holds its last value between strobes
    always_ff @(posedge clk_i) begin
        if (res_valid_i) begin
            rsp_o <= rsp_d;
        end
    end

endmodule

// ==== hdl/bfp_dispatch.sv ====
`timescale 1ns/1ps

module bfp_dispatch (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                req_valid_i,
    input  bfp_pkg::bfp_req_t   req_i,
    output logic                sum_valid_o,
    output bfp_pkg::lane_sum_t  sums_o
);

    // First stage of the pipeline
    // Every lane forms a + b or a - b in one extra bit of width,
    // which keeps the result exact for all operand pairs

    bfp_pkg::lane_sum_t sums_d;

    always_comb begin
        bfp_pkg::sum_t a_ext;
        bfp_pkg::sum_t b_ext;

        for (int unsigned i = 0; i < bfp_pkg::NUM_LANES; i++) begin
            // Replicate the sign bit by hand so the extension does not
            // depend on how the element select of the packed array is typed
            a_ext = {req_i.a[i][bfp_pkg::OP_WIDTH-1], req_i.a[i]};
            b_ext = {req_i.b[i][bfp_pkg::OP_WIDTH-1], req_i.b[i]};

            // One subtract flag steers the whole vector
            if (req_i.sub) begin
                sums_d[i] = a_ext - b_ext;
            end else begin
                sums_d[i] = a_ext + b_ext;
            end
        end
    end

    // Valid strobe follows the request by one cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sum_valid_o <= 1'b0;
        end else begin
            sum_valid_o <= req_valid_i;
        end
    end

    // Sums only load with a request and hold otherwise
    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            sums_o <= sums_d;
        end
    end

endmodule

// ==== hdl/bfp_lane.sv ====
`timescale 1ns/1ps

module bfp_lane (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                sum_valid_i,
    input  bfp_pkg::sum_t       sum_i,
    output logic                res_valid_o,
    output bfp_pkg::lane_res_t  res_o
);

    // Second stage, one copy per lane
    // The signed sum becomes sign and magnitude, and the magnitude gets
    // its leading zero count for the collector

    logic           sign;
    bfp_pkg::mag_t  mag;
    bfp_pkg::cnt_t  lz_cnt;
    logic           lz_empty;

    assign sign = sum_i[bfp_pkg::MAG_WIDTH-1];

    // The most negative sum, -65536, negates to 17'h10000
    // That still fits the unsigned magnitude, so no saturation is needed
    assign mag = sign ? bfp_pkg::mag_t'(-sum_i) : bfp_pkg::mag_t'(sum_i);

    // Leading zero mode, a zero magnitude reads MAG_WIDTH - 1 with empty set
    add_lzc #(
        .WIDTH (bfp_pkg::MAG_WIDTH),
        .MODE  (1'b1)
    ) u_lzc (
        .in_i    (mag),
        .cnt_o   (lz_cnt),
        .empty_o (lz_empty)
    );

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= sum_valid_i;
        end
    end

    // Result fields load together on a valid sum
    always_ff @(posedge clk_i) begin
        if (sum_valid_i) begin
            res_o.sign  <= sign;
            res_o.mag   <= mag;
            res_o.cnt   <= lz_cnt;
            res_o.empty <= lz_empty;
        end
    end

endmodule

// ==== hdl/bfp_norm_top.sv ====
`timescale 1ns/1ps

module bfp_norm_top (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                req_valid_i,
    input  bfp_pkg::bfp_req_t   req_i,
    output logic                rsp_valid_o,
    output bfp_pkg::bfp_rsp_t   rsp_o
);

    // Three stage pipeline, dispatcher then lanes then collector
    // A new vector may enter on every cycle

    logic                                           sum_valid;
    bfp_pkg::lane_sum_t                             sums;
    logic [bfp_pkg::NUM_LANES-1:0]                  res_valid;
    bfp_pkg::lane_res_t [bfp_pkg::NUM_LANES-1:0]    res;

    bfp_dispatch u_dispatch (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .sum_valid_o (sum_valid),
        .sums_o      (sums)
    );

    for (genvar k = 0; k < bfp_pkg::NUM_LANES; k++) begin : g_lane
        bfp_lane u_lane (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .sum_valid_i (sum_valid),
            .sum_i       (sums[k]),
            .res_valid_o (res_valid[k]),
            .res_o       (res[k])
        );
    end

    // All lanes share one strobe, so lane zero speaks for the rest
    bfp_collect u_collect (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .res_valid_i (res_valid[0]),
        .res_i       (res),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

endmodule

// ==== hdl/bfp_pkg.sv ====
package bfp_pkg;

    // Number of parallel lanes in one block
    localparam int unsigned NUM_LANES = 4;

    // Operand width at the input
    localparam int unsigned OP_WIDTH = 16;

    // One extra bit holds the carry of a sum or the borrow of a difference
    localparam int unsigned MAG_WIDTH = OP_WIDTH + 1;

    // Wide enough for any leading zero count of a MAG_WIDTH magnitude
    localparam int unsigned CNT_WIDTH = $clog2(MAG_WIDTH);

    typedef logic signed [OP_WIDTH-1:0]  operand_t;
    typedef logic signed [MAG_WIDTH-1:0] sum_t;
    typedef logic        [MAG_WIDTH-1:0] mag_t;
    typedef logic        [CNT_WIDTH-1:0] cnt_t;

    // One input vector, the subtract flag applies to every lane
    typedef struct packed {
        logic                       sub;
        operand_t [NUM_LANES-1:0]   a;
        operand_t [NUM_LANES-1:0]   b;
    } bfp_req_t;

    // Lane sums from the dispatcher, one entry per lane
    typedef sum_t [NUM_LANES-1:0] lane_sum_t;

    // Sign and magnitude of one lane with its leading zero count
    // The empty flag marks a zero magnitude
    typedef struct packed {
        logic sign;
        mag_t mag;
        cnt_t cnt;
        logic empty;
    } lane_res_t;

    // Normalized block, all mantissas share one shift
    typedef struct packed {
        logic [NUM_LANES-1:0]   sign;
        mag_t [NUM_LANES-1:0]   mant;
        cnt_t                   shift;
        logic                   all_zero;
    } bfp_rsp_t;

endpackage

// ==== testbench/bfp_norm_chk.sv ====
`timescale 1ns/1ps

module bfp_norm_chk (
    input logic              clk_i,
    input logic              rst_n_i,
    input logic              req_valid_i,
    input logic              rsp_valid_o,
    input bfp_pkg::bfp_rsp_t rsp_o
);

    // Three register stages put each response exactly three edges behind its request
    a_rsp_latency: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $past(req_valid_i, 3) |-> rsp_valid_o
    ) else $error("Response strobe missing three cycles after a request");

    // No response strobe without a request three cycles earlier
    a_no_spurious_rsp: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !$past(req_valid_i, 3) |-> !rsp_valid_o
    ) else $error("Response strobe without a matching request");

    // A block of zeros is never shifted and carries no mantissa bits
    a_all_zero_rsp: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (rsp_valid_o && rsp_o.all_zero) |-> (rsp_o.shift == '0 && rsp_o.mant == '0)
    ) else $error("All-zero response with a nonzero shift or mantissa");

endmodule

bind bfp_norm_top bfp_norm_chk u_chk (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
);

// ==== testbench/bfp_norm_tb.sv ====
`timescale 1ns/1ps

module bfp_norm_tb;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    // Latency is three cycles, so a response this late is treated as lost
    localparam int DRAIN_LIMIT  = 8;

    // The watchdog budget grows with the number of vectors in each test
    localparam int NUM_ADD     = 5;
    localparam int NUM_SUB     = 3;
    localparam int NUM_ZERO    = 4;
    localparam int NUM_RAND    = 64;
    localparam int NUM_GAP     = 16;
    localparam int NUM_VECTORS = NUM_ADD + NUM_SUB + NUM_ZERO + NUM_RAND + NUM_GAP;
    localparam int WATCHDOG_NS = (NUM_VECTORS * 10 + RESET_CYCLES) * CLK_PERIOD;

    logic               clk;
    logic               rst_n;
    logic               req_valid;
    bfp_pkg::bfp_req_t  req;
    logic               rsp_valid;
    bfp_pkg::bfp_rsp_t  rsp;

    // Expected responses, oldest request at the head
    bfp_pkg::bfp_rsp_t  exp_q[$];
    int                 mismatch_cnt = 0;
    int                 protocol_cnt = 0;
    int                 seed = 49;

    bfp_norm_top dut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .req_valid_i (req_valid),
        .req_i       (req),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Reference model built from the arithmetic rules of the normalizer
    function automatic bfp_pkg::bfp_rsp_t model_block(input bfp_pkg::bfp_req_t r);
        bfp_pkg::bfp_rsp_t m;
        int a;
        int b;
        int sum;
        int lz;
        int min_lz;
        int mag [bfp_pkg::NUM_LANES];
        m = '0;
        // Larger than any real count, so it only survives when every lane is zero
        min_lz = bfp_pkg::MAG_WIDTH;
        for (int i = 0; i < bfp_pkg::NUM_LANES; i++) begin
            a = $signed(r.a[i]);
            b = $signed(r.b[i]);
            sum = r.sub ? a - b : a + b;
            m.sign[i] = (sum < 0);
            mag[i] = (sum < 0) ? -sum : sum;
            // Walk down from the top bit of the 17-bit magnitude
            lz = 0;
            while (lz < bfp_pkg::MAG_WIDTH && mag[i][bfp_pkg::MAG_WIDTH - 1 - lz] == 1'b0) begin
                lz++;
            end
            if (mag[i] != 0 && lz < min_lz) begin
                min_lz = lz;
            end
        end
        if (min_lz == bfp_pkg::MAG_WIDTH) begin
            m.all_zero = 1'b1;
        end else begin
            m.shift = bfp_pkg::cnt_t'(min_lz);
            for (int i = 0; i < bfp_pkg::NUM_LANES; i++) begin
                m.mant[i] = bfp_pkg::mag_t'(mag[i] << min_lz);
            end
        end
        return m;
    endfunction

    function automatic bfp_pkg::bfp_req_t make_req(
        input logic sub,
        input int a0, input int a1, input int a2, input int a3,
        input int b0, input int b1, input int b2, input int b3
    );
        bfp_pkg::bfp_req_t r;
        r.sub  = sub;
        r.a[0] = bfp_pkg::operand_t'(a0);
        r.a[1] = bfp_pkg::operand_t'(a1);
        r.a[2] = bfp_pkg::operand_t'(a2);
        r.a[3] = bfp_pkg::operand_t'(a3);
        r.b[0] = bfp_pkg::operand_t'(b0);
        r.b[1] = bfp_pkg::operand_t'(b1);
        r.b[2] = bfp_pkg::operand_t'(b2);
        r.b[3] = bfp_pkg::operand_t'(b3);
        return r;
    endfunction

    // Operands are scaled down by a random amount so the zero counts spread out
    function automatic bfp_pkg::bfp_req_t random_req();
        bfp_pkg::bfp_req_t r;
        int value;
        int scale;
        r.sub = 1'($random(seed));
        for (int i = 0; i < bfp_pkg::NUM_LANES; i++) begin
            value = bfp_pkg::operand_t'($random(seed));
            scale = $unsigned($random(seed)) % 16;
            r.a[i] = bfp_pkg::operand_t'(value >>> scale);
            value = bfp_pkg::operand_t'($random(seed));
            scale = $unsigned($random(seed)) % 16;
            r.b[i] = bfp_pkg::operand_t'(value >>> scale);
        end
        return r;
    endfunction

    task automatic compare_rsp(input bfp_pkg::bfp_rsp_t exp, input bfp_pkg::bfp_rsp_t got);
        assert (got.all_zero == exp.all_zero) else begin
            mismatch_cnt++;
            $display("Mismatch at %0t: all_zero is %0b, expected %0b",
                     $time, got.all_zero, exp.all_zero);
        end
        assert (got.shift == exp.shift) else begin
            mismatch_cnt++;
            $display("Mismatch at %0t: shift is %0d, expected %0d", $time, got.shift, exp.shift);
        end
        for (int i = 0; i < bfp_pkg::NUM_LANES; i++) begin
            assert (got.sign[i] == exp.sign[i]) else begin
                mismatch_cnt++;
                $display("Mismatch at %0t: sign of lane %0d is %0b, expected %0b",
                         $time, i, got.sign[i], exp.sign[i]);
            end
            assert (got.mant[i] == exp.mant[i]) else begin
                mismatch_cnt++;
                $display("Mismatch at %0t: mant of lane %0d is %h, expected %h",
                         $time, i, got.mant[i], exp.mant[i]);
            end
        end
    endtask

    // Outputs are sampled on the falling edge, half a cycle away from any update
    always @(negedge clk) begin
        if (rst_n && rsp_valid) begin
            assert (exp_q.size() != 0) else begin
                protocol_cnt++;
                $display("Error at %0t: a response arrived with no request outstanding", $time);
            end
            if (exp_q.size() != 0) begin
                compare_rsp(exp_q.pop_front(), rsp);
            end
        end
    end

    // Every task starts and ends 1 ns after a rising edge
    task automatic send(input bfp_pkg::bfp_req_t r);
        req       = r;
        req_valid = 1'b1;
        exp_q.push_back(model_block(r));
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            idle(1);
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            protocol_cnt++;
            $display("Error at %0t: %0d responses never arrived", $time, exp_q.size());
            exp_q.delete();
        end
    endtask

    // The pipeline must stay quiet while nothing has been sent
    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (rsp_valid === 1'b0) else begin
                protocol_cnt++;
                $display("Error at %0t: response strobe rose with no request sent", $time);
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic test_add();
        // Lanes of very different size, only the largest reaches the top bit
        send(make_req(1'b0, 1000, 2000, -3000, 50, 24, -48, 100, 0));
        send(make_req(1'b0, 1, 2, 3, 4, 0, 0, 0, 0));
        send(make_req(1'b0, 32767, 16384, -1, 256, 32767, 0, -1, 1));
        // The most negative sum needs all 17 magnitude bits
        send(make_req(1'b0, -32768, 5, 0, 0, -32768, -5, 0, 1));
        send(make_req(1'b0, 300, -7, 12, 9, 212, -1, 4, -9));
        drain();
    endtask

    task automatic test_sub();
        // Extreme difference of -32768 and 32767 gives a magnitude of 65535
        send(make_req(1'b1, -32768, 100, 0, 5, 32767, 200, 1, 5));
        send(make_req(1'b1, 32767, -32768, 10, -10, -32768, 32767, 20, -20));
        send(make_req(1'b1, 64, -64, 0, 1, 128, 64, 3, 1));
        drain();
    endtask

    task automatic test_zero();
        send(make_req(1'b0, 0, 0, 12, 0, 0, 0, 0, 0));
        send(make_req(1'b1, 7, 0, 9, 0, 7, 0, 1, 0));
        // Whole block of zeros, from plain zeros and from equal operands
        send(make_req(1'b0, 0, 0, 0, 0, 0, 0, 0, 0));
        send(make_req(1'b1, 123, -5, 0, 32767, 123, -5, 0, 32767));
        drain();
    endtask

    task automatic test_random();
        // A new vector on every cycle keeps three vectors in flight
        repeat (NUM_RAND) begin
            send(random_req());
        end
        drain();
    endtask

    task automatic test_gaps();
        int gap;
        for (int n = 0; n < NUM_GAP; n++) begin
            send(random_req());
            gap = $unsigned($random(seed)) % 6;
            idle(gap);
        end
        drain();
    endtask

    initial begin
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_idle(20);
        test_add();
        test_sub();
        test_zero();
        test_random();
        test_gaps();

        $display("Errors: %0d mismatches, %0d protocol errors", mismatch_cnt, protocol_cnt);
        if (mismatch_cnt == 0 && protocol_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("sim failed");
        $finish;
    end

endmodule
